//--- hdl/fight_pkg.sv
package fight_pkg;

	// Frame pacing, shortened for simulation
	localparam int FRAME_CYCLES = 20;	// About 833334 at 50 MHz on the board
	localparam int FRAME_W = $clog2(FRAME_CYCLES);

	// Playfield geometry in pixels
	localparam int X_W = 9;
	localparam logic [X_W-1:0] SCREEN_W = X_W'(320);
	localparam logic [X_W-1:0] SPRITE_W = X_W'(64);

	// Where the fighters stand after reset
	localparam logic [X_W-1:0] X0_START = X_W'(1);
	localparam logic [X_W-1:0] X1_START = X_W'(255);

	// Movement per frame update
	localparam logic [X_W-1:0] WALK_STEP = X_W'(2);
	localparam logic [X_W-1:0] KNOCK_STEP = X_W'(2);

	// Hitbox window, measured from the victim's left edge
	localparam logic [X_W-1:0] HIT_NEAR = X_W'(20);
	localparam logic [X_W-1:0] HIT_FAR = X_W'(44);

	// Length of a hit in frame updates
	localparam int STUN_W = 2;
	localparam logic [STUN_W-1:0] STUN_FRAMES = STUN_W'(3);

	localparam int SCORE_W = 4;	// One hex digit per fighter

	// Per fighter command for one frame update
	typedef enum logic [2:0] {
		CMD_IDLE,
		CMD_WALK_L,
		CMD_WALK_R,
		CMD_ATTACK,
		CMD_RECOIL
	} fight_cmd_e;

endpackage

//--- hdl/frame_tick.sv
`timescale 1ns/1ps

module frame_tick (
	input  logic clk,
	input  logic resetn,
	output logic frame
);
	import fight_pkg::*;

	logic [FRAME_W-1:0] count;
	logic last;

	assign last = (count == FRAME_W'(FRAME_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
			frame <= 1'b0;
		end else begin
			count <= last ? '0 : count + 1'b1;
			frame <= last;	// High for one clk per frame
		end
	end

endmodule

//--- hdl/fighter_decode.sv
`timescale 1ns/1ps

module fighter_decode (
	input  logic clk,
	input  logic resetn,
	input  logic frame,
	input  logic [3:0] key,
	input  logic [1:0] attack,
	input  logic stunned_0,
	input  logic stunned_1,
	output fight_pkg::fight_cmd_e cmd_0,
	output fight_pkg::fight_cmd_e cmd_1,
	output logic facing_0,
	output logic facing_1,
	output logic cmd_valid
);
	import fight_pkg::*;

	logic [3:0] btn;	// Keys after inversion, 1 = pressed
	fight_cmd_e next_0;
	fight_cmd_e next_1;

	// Stun beats walking, walking beats attacking
	function automatic fight_cmd_e pick_cmd(input logic stunned, input logic right,
			input logic left, input logic atk);
		if (stunned)
			pick_cmd = CMD_RECOIL;
		else if (right)
			pick_cmd = CMD_WALK_R;
		else if (left)
			pick_cmd = CMD_WALK_L;
		else if (atk)
			pick_cmd = CMD_ATTACK;
		else
			pick_cmd = CMD_IDLE;
	endfunction

	// Facing only turns on a walk, 0 is right
	function automatic logic next_facing(input fight_cmd_e cmd, input logic facing);
		case (cmd)
			CMD_WALK_R: next_facing = 1'b0;
			CMD_WALK_L: next_facing = 1'b1;
			default:    next_facing = facing;
		endcase
	endfunction

	assign btn = ~key;
	assign next_0 = pick_cmd(stunned_0, btn[0], btn[1], attack[0]);
	assign next_1 = pick_cmd(stunned_1, btn[2], btn[3], attack[1]);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cmd_0 <= CMD_IDLE;
			cmd_1 <= CMD_IDLE;
			facing_0 <= 1'b0;
			facing_1 <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= frame;	// Starts the engine update one cycle later
			if (frame) begin
				cmd_0 <= next_0;
				cmd_1 <= next_1;
				facing_0 <= next_facing(next_0, facing_0);
				facing_1 <= next_facing(next_1, facing_1);
			end
		end
	end

endmodule

//--- hdl/combat_engine.sv
`timescale 1ns/1ps

module combat_engine (
	input  logic clk,
	input  logic resetn,
	input  logic cmd_valid,
	input  fight_pkg::fight_cmd_e cmd_0,
	input  fight_pkg::fight_cmd_e cmd_1,
	input  logic facing_0,
	input  logic facing_1,
	output logic [fight_pkg::X_W-1:0] pos_x_0,
	output logic [fight_pkg::X_W-1:0] pos_x_1,
	output logic stunned_0,
	output logic stunned_1,
	output logic hit_0,
	output logic hit_1
);
	import fight_pkg::*;

	logic [STUN_W-1:0] stun_cnt;	// Shared, only one fighter is hurt at a time
	logic victim_0;
	logic victim_1;
	logic knock_left;	// Attacker's facing at the hit
	logic stun_on;
	logic in_range_0;
	logic in_range_1;
	logic strike_0;
	logic strike_1;

	// One step left or right, skipped if it would leave the playfield
	function automatic logic [X_W-1:0] step_pos(input logic [X_W-1:0] pos,
			input logic left, input logic [X_W-1:0] step);
		logic [X_W:0] far_edge;
		far_edge = {1'b0, pos} + {1'b0, SPRITE_W} + {1'b0, step};
		if (left)
			step_pos = (pos >= step) ? pos - step : pos;
		else
			step_pos = (far_edge <= {1'b0, SCREEN_W}) ? pos + step : pos;
	endfunction

	// Leading edge of the attacker against the victim's hitbox window
	function automatic logic in_window(input logic [X_W-1:0] atk_pos,
			input logic atk_left, input logic [X_W-1:0] vic_pos);
		logic [X_W:0] lead_x;
		logic [X_W:0] near_x;
		logic [X_W:0] far_x;
		lead_x = atk_left ? {1'b0, atk_pos} : {1'b0, atk_pos} + {1'b0, SPRITE_W};
		near_x = {1'b0, vic_pos} + {1'b0, HIT_NEAR};
		far_x = {1'b0, vic_pos} + {1'b0, HIT_FAR};
		in_window = (lead_x >= near_x) && (lead_x <= far_x);
	endfunction

	assign stun_on = (stun_cnt != '0);
	assign stunned_0 = stun_on & victim_0;
	assign stunned_1 = stun_on & victim_1;

	// Hit test on positions from before this update
	assign in_range_0 = in_window(pos_x_0, facing_0, pos_x_1);
	assign in_range_1 = in_window(pos_x_1, facing_1, pos_x_0);
	assign strike_0 = (cmd_0 == CMD_ATTACK) && in_range_0;
	assign strike_1 = (cmd_1 == CMD_ATTACK) && in_range_1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pos_x_0 <= X0_START;
			pos_x_1 <= X1_START;
			stun_cnt <= '0;
			victim_0 <= 1'b0;
			victim_1 <= 1'b0;
			knock_left <= 1'b0;
			hit_0 <= 1'b0;
			hit_1 <= 1'b0;
		end else begin
			hit_0 <= 1'b0;
			hit_1 <= 1'b0;
			if (cmd_valid) begin
				if (stun_on) begin
					// Only the recoil moves, walks and attacks are dropped
					if (cmd_0 == CMD_RECOIL)
						pos_x_0 <= step_pos(pos_x_0, knock_left, KNOCK_STEP);
					if (cmd_1 == CMD_RECOIL)
						pos_x_1 <= step_pos(pos_x_1, knock_left, KNOCK_STEP);
					stun_cnt <= stun_cnt - 1'b1;
				end else begin
					if (cmd_0 == CMD_WALK_L || cmd_0 == CMD_WALK_R)
						pos_x_0 <= step_pos(pos_x_0, cmd_0 == CMD_WALK_L, WALK_STEP);
					if (cmd_1 == CMD_WALK_L || cmd_1 == CMD_WALK_R)
						pos_x_1 <= step_pos(pos_x_1, cmd_1 == CMD_WALK_L, WALK_STEP);

					if (strike_0) begin	// Fighter 0 wins a double attack
						hit_0 <= 1'b1;
						victim_0 <= 1'b0;
						victim_1 <= 1'b1;
						knock_left <= facing_0;
						stun_cnt <= STUN_FRAMES;
					end else if (strike_1) begin
						hit_1 <= 1'b1;
						victim_0 <= 1'b1;
						victim_1 <= 1'b0;
						knock_left <= facing_1;
						stun_cnt <= STUN_FRAMES;
					end
				end
			end
		end
	end

endmodule

//--- hdl/score_display.sv
`timescale 1ns/1ps

module score_display (
	input  logic clk,
	input  logic resetn,
	input  logic hit_0,
	input  logic hit_1,
	output logic [6:0] hex_0,
	output logic [6:0] hex_1
);
	import fight_pkg::*;

	logic [SCORE_W-1:0] score_0;
	logic [SCORE_W-1:0] score_1;

	// Active low segments, bit 6 is g
	function automatic logic [6:0] seg7(input logic [SCORE_W-1:0] digit);
		case (digit)
			4'h0: seg7 = 7'b100_0000;
			4'h1: seg7 = 7'b111_1001;
			4'h2: seg7 = 7'b010_0100;
			4'h3: seg7 = 7'b011_0000;
			4'h4: seg7 = 7'b001_1001;
			4'h5: seg7 = 7'b001_0010;
			4'h6: seg7 = 7'b000_0010;
			4'h7: seg7 = 7'b111_1000;
			4'h8: seg7 = 7'b000_0000;
			4'h9: seg7 = 7'b001_1000;
			4'hA: seg7 = 7'b000_1000;
			4'hB: seg7 = 7'b000_0011;
			4'hC: seg7 = 7'b100_0110;
			4'hD: seg7 = 7'b010_0001;
			4'hE: seg7 = 7'b000_0110;
			4'hF: seg7 = 7'b000_1110;
			default: seg7 = 7'h7f;	// Blank
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			score_0 <= '0;
			score_1 <= '0;
		end else begin
			// Wraps past F back to 0
			if (hit_0)
				score_0 <= score_0 + 1'b1;
			if (hit_1)
				score_1 <= score_1 + 1'b1;
		end
	end

	assign hex_0 = seg7(score_0);
	assign hex_1 = seg7(score_1);

endmodule

//--- hdl/fight_top.sv
`timescale 1ns/1ps

module fight_top (
	input  logic clk,
	input  logic resetn,
	input  logic [3:0] key,
	input  logic [1:0] attack,
	output logic [fight_pkg::X_W-1:0] pos_x_0,
	output logic [fight_pkg::X_W-1:0] pos_x_1,
	output logic stunned_0,
	output logic stunned_1,
	output logic [6:0] hex_0,
	output logic [6:0] hex_1
);
	import fight_pkg::*;

	logic frame;
	logic cmd_valid;
	fight_cmd_e cmd_0;
	fight_cmd_e cmd_1;
	logic facing_0;
	logic facing_1;
	logic hit_0;	// Scoring pulses
	logic hit_1;

	frame_tick u_frame (
		.clk    (clk),
		.resetn (resetn),
		.frame  (frame)
	);

	fighter_decode u_decode (
		.clk       (clk),
		.resetn    (resetn),
		.frame     (frame),
		.key       (key),
		.attack    (attack),
		.stunned_0 (stunned_0),
		.stunned_1 (stunned_1),
		.cmd_0     (cmd_0),
		.cmd_1     (cmd_1),
		.facing_0  (facing_0),
		.facing_1  (facing_1),
		.cmd_valid (cmd_valid)
	);

	combat_engine u_engine (
		.clk       (clk),
		.resetn    (resetn),
		.cmd_valid (cmd_valid),
		.cmd_0     (cmd_0),
		.cmd_1     (cmd_1),
		.facing_0  (facing_0),
		.facing_1  (facing_1),
		.pos_x_0   (pos_x_0),
		.pos_x_1   (pos_x_1),
		.stunned_0 (stunned_0),
		.stunned_1 (stunned_1),
		.hit_0     (hit_0),
		.hit_1     (hit_1)
	);

	score_display u_score (
		.clk    (clk),
		.resetn (resetn),
		.hit_0  (hit_0),
		.hit_1  (hit_1),
		.hex_0  (hex_0),
		.hex_1  (hex_1)
	);

endmodule

//--- tests/tb_fight.sv
`timescale 1ns/1ps

module tb_fight;
	import fight_pkg::*;

	localparam int CLK_NS = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_FRAMES = 211;	// Sum of the directed holds below
	localparam int RANDOM_FRAMES = 300;
	localparam int TOTAL_FRAMES = DIRECTED_FRAMES + RANDOM_FRAMES;
	localparam int WATCHDOG_NS = (RESET_CYCLES + (TOTAL_FRAMES + 3) * FRAME_CYCLES) * CLK_NS
		+ 2000;

	// Command codes of the reference model
	localparam int C_IDLE = 0;
	localparam int C_WALK_L = 1;
	localparam int C_WALK_R = 2;
	localparam int C_ATTACK = 3;
	localparam int C_RECOIL = 4;

	typedef struct packed {
		int p0;
		int p1;
		int stun;
		logic vic0;
		logic vic1;
		logic kleft;
		logic face0;
		logic face1;
		logic [3:0] sc0;
		logic [3:0] sc1;
	} model_t;

	logic clk;
	logic resetn;
	logic [3:0] key;
	logic [1:0] attack;
	logic [X_W-1:0] pos_x_0;
	logic [X_W-1:0] pos_x_1;
	logic stunned_0;
	logic stunned_1;
	logic [6:0] hex_0;
	logic [6:0] hex_1;

	logic [5:0] pending[$];	// {attack, key} per frame with the oldest first
	int frames_sent = 0;
	int checked = 0;

	fight_top u_dut (
		.clk       (clk),
		.resetn    (resetn),
		.key       (key),
		.attack    (attack),
		.pos_x_0   (pos_x_0),
		.pos_x_1   (pos_x_1),
		.stunned_0 (stunned_0),
		.stunned_1 (stunned_1),
		.hex_0     (hex_0),
		.hex_1     (hex_1)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic int choose_cmd(input logic stunned, input logic right, input logic left,
			input logic atk);
		if (stunned)
			return C_RECOIL;
		if (right)
			return C_WALK_R;
		if (left)
			return C_WALK_L;
		return atk ? C_ATTACK : C_IDLE;
	endfunction

	// Step is dropped when the sprite would leave the screen
	function automatic int moved_pos(input int pos, input logic left, input int step);
		if (left)
			return (pos >= step) ? pos - step : pos;
		return (pos + int'(SPRITE_W) + step <= int'(SCREEN_W)) ? pos + step : pos;
	endfunction

	function automatic logic lands(input int atk_pos, input logic atk_left, input int vic_pos);
		int lead;
		lead = atk_left ? atk_pos : atk_pos + int'(SPRITE_W);
		return (lead >= vic_pos + int'(HIT_NEAR)) && (lead <= vic_pos + int'(HIT_FAR));
	endfunction

	function automatic model_t model_update(input model_t s, input logic [3:0] key_n,
			input logic [1:0] atk);
		model_t n;
		logic [3:0] b;
		int c0;
		int c1;
		n = s;
		b = ~key_n;
		c0 = choose_cmd(s.stun != 0 && s.vic0, b[0], b[1], atk[0]);
		c1 = choose_cmd(s.stun != 0 && s.vic1, b[2], b[3], atk[1]);
		if (c0 == C_WALK_R || c0 == C_WALK_L)
			n.face0 = (c0 == C_WALK_L);
		if (c1 == C_WALK_R || c1 == C_WALK_L)
			n.face1 = (c1 == C_WALK_L);
		if (s.stun != 0) begin
			if (c0 == C_RECOIL)
				n.p0 = moved_pos(s.p0, s.kleft, int'(KNOCK_STEP));
			if (c1 == C_RECOIL)
				n.p1 = moved_pos(s.p1, s.kleft, int'(KNOCK_STEP));
			n.stun = s.stun - 1;
		end else begin
			if (c0 == C_WALK_R || c0 == C_WALK_L)
				n.p0 = moved_pos(s.p0, c0 == C_WALK_L, int'(WALK_STEP));
			if (c1 == C_WALK_R || c1 == C_WALK_L)
				n.p1 = moved_pos(s.p1, c1 == C_WALK_L, int'(WALK_STEP));
			if (c0 == C_ATTACK && lands(s.p0, n.face0, s.p1)) begin	// Fighter 0 goes first
				n.sc0 = s.sc0 + 4'd1;
				{n.vic0, n.vic1, n.kleft, n.stun} = {1'b0, 1'b1, n.face0, 32'd3};
			end else if (c1 == C_ATTACK && lands(s.p1, n.face1, s.p0)) begin
				n.sc1 = s.sc1 + 4'd1;
				{n.vic0, n.vic1, n.kleft, n.stun} = {1'b1, 1'b0, n.face1, 32'd3};
			end
		end
		return n;
	endfunction

	// Active low with bit 6 as segment g
	function automatic logic [6:0] seg_ref(input logic [3:0] d);
		logic [6:0] table_low[16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
		return table_low[d];
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected);
			$display("TEST FAIL");
			$fatal(1, "Output mismatch on %s", name);
		end
	endtask

	task automatic compare_outputs(input model_t m);
		check_val("pos_x_0", 32'(pos_x_0), 32'(m.p0));
		check_val("pos_x_1", 32'(pos_x_1), 32'(m.p1));
		check_val("stunned_0", 32'(stunned_0), 32'(m.stun != 0 && m.vic0));
		check_val("stunned_1", 32'(stunned_1), 32'(m.stun != 0 && m.vic1));
		check_val("hex_0", 32'(hex_0), 32'(seg_ref(m.sc0)));
		check_val("hex_1", 32'(hex_1), 32'(seg_ref(m.sc1)));
	endtask

	// Holds one input set for n whole frames
	task automatic hold(input int n, input logic [3:0] k, input logic [1:0] a);
		repeat (n) begin
			key = k;
			attack = a;
			pending.push_back({a, k});
			frames_sent++;
			repeat (FRAME_CYCLES) @(posedge clk);
			#2;
		end
	endtask

	initial begin : compare
		model_t st;
		logic [5:0] in_set;
		logic fresh;
		st = '{p0: int'(X0_START), p1: int'(X1_START), default: '0};
		wait (resetn === 1'b1);
		repeat (FRAME_CYCLES - 2) @(posedge clk);
		@(negedge clk);
		compare_outputs(st);	// Reset state
		forever begin
			repeat (FRAME_CYCLES) @(posedge clk);
			@(negedge clk);
			fresh = (pending.size() > 0);
			if (fresh) begin
				in_set = pending.pop_front();
				st = model_update(st, in_set[3:0], in_set[5:4]);
			end
			compare_outputs(st);
			if (fresh)
				checked++;
		end
	end

	initial begin
		#WATCHDOG_NS;
		$display("Timeout: the frames did not all complete within the expected time");
		$display("TEST FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		resetn = 1'b0;
		key = 4'hF;
		attack = 2'b00;
		void'($urandom(16));
		repeat (RESET_CYCLES) @(posedge clk);
		#2 resetn = 1'b1;
		repeat (2) @(posedge clk);	// Lines the holds up with the frame ticks
		#2;
		hold(1, 4'hF, 2'b00);
		hold(3, 4'b1101, 2'b00);	// Fighter 0 left against the wall
		hold(5, 4'b0111, 2'b00);
		hold(8, 4'b1011, 2'b00);	// Fighter 1 right into the wall
		hold(50, 4'b0110, 2'b00);	// Both close in
		hold(1, 4'hF, 2'b10);	// Out of range with facing kept
		hold(1, 4'hF, 2'b01);
		hold(5, 4'b0111, 2'b00);
		hold(1, 4'hF, 2'b10);	// Left facing hit
		hold(1, 4'hF, 2'b10);	// Attack in range during the stun scores nothing
		hold(2, 4'b0110, 2'b00);	// Walks ignored during the stun
		hold(3, 4'b1110, 2'b00);
		hold(1, 4'hF, 2'b11);	// Double attack
		hold(3, 4'hF, 2'b00);
		for (int i = 0; i < 18; i++) begin	// Score wraps and the last recoil clips
			hold(3, 4'b1110, 2'b00);
			hold(1, 4'hF, 2'b01);
			hold(3, 4'hF, 2'b00);
		end
		for (int i = 0; i < RANDOM_FRAMES; i++)
			hold(1, 4'($urandom), 2'($urandom));
		wait (checked == frames_sent);
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- vlog.f
hdl/fight_pkg.sv
hdl/frame_tick.sv
hdl/fighter_decode.sv
hdl/combat_engine.sv
hdl/score_display.sv
hdl/fight_top.sv
tests/tb_fight.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f vlog.f --top-module tb_fight -o tb_fight \
	&& ./obj_dir/tb_fight | tee /dev/stderr | grep -q "TEST PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
